// File: logic/bpu_pkg.sv
// one update bus per cycle; 64-entry direct-mapped btb; stack and target queue wrap silently
package bpu_pkg;

  localparam int btb_idx_w   = 6;
  localparam int btb_tag_w   = 10;
  localparam int btb_entries = 1 << btb_idx_w;

  localparam int ras_depth   = 8;
  localparam int ras_ptr_w   = 3;

  localparam int queue_depth = 8;
  localparam int queue_ptr_w = 3;

  // jump types as reported by execute
  localparam logic [1:0] jt_branch = 2'd0;
  localparam logic [1:0] jt_call   = 2'd1;
  localparam logic [1:0] jt_return = 2'd2;

  typedef struct packed {
    logic [1:0]           jump_type;
    logic [btb_tag_w-1:0] tag;
    logic [29:0]          target;     // word address
  } btb_entry_t;

  typedef struct packed {
    logic        flush;       // pipeline flush from elsewhere
    logic        in_excp;
    logic        is_ertn;
    logic [31:0] pc;
    logic        may_jump;    // instruction is a branch
    logic        need_jump;   // resolved taken
    logic        pre_fail;    // execute already saw the mispredict
    logic [31:0] right_target;
    logic [1:0]  jump_type;
  } bpu_update_t;

  typedef struct packed {
    logic [31:0] next_pc;
    logic [3:0]  pc_valid;
    logic [3:0]  pc_is_jump;  // one-hot or zero
  } fetch_pred_t;

  typedef struct packed {
    logic       entry_valid;  // valid and tag matches the lookup pc
    logic [1:0] ctr;
    btb_entry_t entry;
  } slot_read_t;

  typedef struct packed {
    slot_read_t [3:0] slot;
  } group_read_t;

  // folded tag shared by lookup and update
  function automatic logic [btb_tag_w-1:0] pc_tag(input logic [31:0] addr);
    return addr[17:8] ^ addr[27:18];
  endfunction

  function automatic logic upd_meaningful(input bpu_update_t u);
    return u.may_jump && !u.in_excp && !u.is_ertn;
  endfunction

endpackage

// File: logic/bpu_ctrl.sv
// queue and stack strobes stay low until the first edge after reset; flush is combinational
`timescale 1ns/1ps

module bpu_ctrl
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic        fetch_stall,
  input  bpu_update_t upd,
  input  group_read_t grp,
  input  logic        upd_entry_hit,
  input  logic [29:0] top_target,
  input  logic [29:0] head_target,
  input  logic        head_valid,
  output fetch_pred_t pred,
  output logic        bpu_flush,
  output logic [31:0] bpu_jump_pc,
  output logic        ras_push,
  output logic        ras_pop,
  output logic [29:0] ras_push_target,
  output logic        q_push,
  output logic        q_pop,
  output logic        q_clear,
  output logic [29:0] q_push_target
);

  logic [3:0] live;
  logic [3:0] cand;
  logic       hit;
  logic [1:0] hit_slot;
  logic [3:0] jump_mask;
  logic [3:0] upto_mask;
  btb_entry_t sel;

  logic       upd_valid;
  logic       upd_resolve;
  logic       target_miss;
  logic       call_taken;
  logic       ret_taken;
  logic       strobe_en;

  always_ff @(posedge clk)
  begin
    if (reset)
      strobe_en <= 1'b0;
    else
      strobe_en <= 1'b1;
  end

  // slots before the entry point of the group are dead
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      live[k] = 2'(k) >= pc[3:2];
      cand[k] = live[k] && grp.slot[k].entry_valid && (grp.slot[k].ctr >= 2'd2);
    end
  end

  always_comb
  begin
    hit      = 1'b0;
    hit_slot = 2'd0;
    for (int k = 3; k >= 0; k--) // downward so the lowest slot wins
    begin
      if (cand[k])
      begin
        hit      = 1'b1;
        hit_slot = 2'(k);
      end
    end
  end

  assign sel       = grp.slot[hit_slot].entry;
  assign jump_mask = hit ? (4'b0001 << hit_slot) : 4'b0000;
  assign upto_mask = (jump_mask << 1) - 4'd1; // all ones for the last slot

  always_comb
  begin
    pred.pc_is_jump = jump_mask;
    if (hit)
    begin
      pred.pc_valid = live & upto_mask;
      if (sel.jump_type == jt_return)
        pred.next_pc = {top_target, 2'b00};
      else
        pred.next_pc = {sel.target, 2'b00};
    end
    else
    begin
      pred.pc_valid = live;
      pred.next_pc  = {pc[31:4] + 28'd1, 4'b0000}; // next aligned group
    end
  end

  assign q_push        = strobe_en && hit && !fetch_stall;
  assign q_push_target = pred.next_pc[31:2];

  // resolved taken branch that was predicted from a valid entry
  assign upd_valid   = upd_meaningful(upd);
  assign upd_resolve = upd_valid && upd.need_jump && !upd.pre_fail && upd_entry_hit && head_valid;
  assign target_miss = upd.right_target[31:2] != head_target;

  assign bpu_flush   = upd_resolve && target_miss;
  assign bpu_jump_pc = upd.right_target;

  assign q_pop   = strobe_en && upd_resolve && !target_miss;
  assign q_clear = strobe_en && (bpu_flush || upd.flush);

  always_comb
  begin
    call_taken = 1'b0;
    ret_taken  = 1'b0;
    if (upd_valid && upd.need_jump)
    begin
      case (upd.jump_type)
        jt_call:   call_taken = 1'b1;
        jt_return: ret_taken  = 1'b1;
        jt_branch: ;                  // stack untouched
        default:   ;
      endcase
    end
  end

  assign ras_push        = strobe_en && call_taken;
  assign ras_push_target = upd.pc[31:2] + 30'd1; // return lands after the call
  assign ras_pop         = strobe_en && ret_taken && !bpu_flush;

endmodule

// File: logic/btb_pht.sv
// direct-mapped on pc[7:2]; a group read never wraps since the group base is 4-aligned
`timescale 1ns/1ps

module btb_pht
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  input  bpu_update_t upd,
  output group_read_t grp,
  output logic        upd_entry_hit
);

  logic [btb_entries-1:0] valid;
  logic [1:0]             pht [btb_entries];
  btb_entry_t             btb [btb_entries];

  logic [btb_tag_w-1:0]   rtag;
  logic [btb_idx_w-1:0]   widx;
  logic [btb_tag_w-1:0]   wtag;
  logic                   upd_valid;
  logic                   tag_match;

  assign rtag = pc_tag(pc);

  for (genvar k = 0; k < 4; k++)
  begin : g_slot
    logic [btb_idx_w-1:0] ridx;

    assign ridx = {pc[7:4], 2'(k)};

    assign grp.slot[k].entry_valid = valid[ridx] && (btb[ridx].tag == rtag);
    assign grp.slot[k].ctr         = pht[ridx];
    assign grp.slot[k].entry       = btb[ridx];
  end

  assign widx      = upd.pc[btb_idx_w+1:2];
  assign wtag      = pc_tag(upd.pc);
  assign upd_valid = upd_meaningful(upd);

  assign upd_entry_hit = valid[widx]; // state before this update
  assign tag_match     = upd_entry_hit && (btb[widx].tag == wtag);

  always_ff @(posedge clk)
  begin
    if (reset)
      valid <= '0;
    else if (upd_valid && upd.need_jump && !tag_match)
      valid[widx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (upd_valid)
    begin
      if (upd.need_jump)
      begin
        btb[widx] <= '{jump_type: upd.jump_type, tag: wtag, target: upd.right_target[31:2]};
        if (!tag_match)
          pht[widx] <= 2'd2;             // allocate weakly taken
        else if (pht[widx] != 2'd3)
          pht[widx] <= pht[widx] + 2'd1;
      end
      else if (tag_match && (pht[widx] != 2'd0))
      begin
        pht[widx] <= pht[widx] - 2'd1;
      end
    end
  end

endmodule

// File: logic/ras.sv
// single pointer; overflow and underflow wrap and overwrite; no repair after a flush
`timescale 1ns/1ps

module ras
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pop,
  input  logic [29:0] push_target,
  output logic [29:0] top_target
);

  logic [29:0]          stack [ras_depth];
  logic [ras_ptr_w-1:0] ptr;      // next free slot
  logic [ras_ptr_w-1:0] top_ptr;

  assign top_ptr    = ptr - ras_ptr_w'(1);
  assign top_target = stack[top_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr <= '0;
    end
    else if (push && !pop)
    begin
      ptr <= ptr + ras_ptr_w'(1);
    end
    else if (pop && !push)
    begin
      ptr <= top_ptr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push && pop)
      stack[top_ptr] <= push_target; // replace top in place
    else if (push)
      stack[ptr] <= push_target;
  end

endmodule

// File: logic/target_queue.sv
// clear beats push and pop; a push into a full queue overwrites the tail slot
`timescale 1ns/1ps

module target_queue
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pop,
  input  logic        clear,
  input  logic [29:0] push_target,
  output logic [29:0] head_target,
  output logic        head_valid
);

  logic [29:0]            mem [queue_depth];
  logic [queue_depth-1:0] valid;
  logic [queue_ptr_w-1:0] head;
  logic [queue_ptr_w-1:0] tail;

  assign head_target = mem[head];
  assign head_valid  = valid[head];

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      valid <= '0;
      head  <= '0;
      tail  <= '0;
    end
    else
    begin
      if (pop)
      begin
        valid[head] <= 1'b0;
        head        <= head + queue_ptr_w'(1);
      end
      if (push) // after pop so a same-slot push stays valid
      begin
        valid[tail] <= 1'b1;
        tail        <= tail + queue_ptr_w'(1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push && !clear)
      mem[tail] <= push_target;
  end

endmodule

// File: logic/bpu_top.sv
// lookup is combinational on pc; every update from execute lands at the next clock edge
`timescale 1ns/1ps

module bpu_top
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic        fetch_stall,
  input  bpu_update_t upd,
  output fetch_pred_t pred,
  output logic        bpu_flush,
  output logic [31:0] bpu_jump_pc
);

  group_read_t grp;
  logic        upd_entry_hit;

  logic        ras_push;
  logic        ras_pop;
  logic [29:0] ras_push_target;
  logic [29:0] top_target;

  logic        q_push;
  logic        q_pop;
  logic        q_clear;
  logic [29:0] q_push_target;
  logic [29:0] head_target;
  logic        head_valid;

  bpu_ctrl ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .pc              (pc),
    .fetch_stall     (fetch_stall),
    .upd             (upd),
    .grp             (grp),
    .upd_entry_hit   (upd_entry_hit),
    .top_target      (top_target),
    .head_target     (head_target),
    .head_valid      (head_valid),
    .pred            (pred),
    .bpu_flush       (bpu_flush),
    .bpu_jump_pc     (bpu_jump_pc),
    .ras_push        (ras_push),
    .ras_pop         (ras_pop),
    .ras_push_target (ras_push_target),
    .q_push          (q_push),
    .q_pop           (q_pop),
    .q_clear         (q_clear),
    .q_push_target   (q_push_target)
  );

  btb_pht btb_i (
    .clk           (clk),
    .reset         (reset),
    .pc            (pc),
    .upd           (upd),
    .grp           (grp),
    .upd_entry_hit (upd_entry_hit)
  );

  ras ras_i (
    .clk         (clk),
    .reset       (reset),
    .push        (ras_push),
    .pop         (ras_pop),
    .push_target (ras_push_target),
    .top_target  (top_target)
  );

  target_queue queue_i (
    .clk         (clk),
    .reset       (reset),
    .push        (q_push),
    .pop         (q_pop),
    .clear       (q_clear),
    .push_target (q_push_target),
    .head_target (head_target),
    .head_valid  (head_valid)
  );

endmodule

// File: dv/bpu_checker.sv
// output sanity checks on bpu_top; one-hot and range checks are skipped while reset is high
`timescale 1ns/1ps

module bpu_checker
  import bpu_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input fetch_pred_t pred,
  input logic        bpu_flush
);

  int fail_count = 0;

  jump_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(pred.pc_is_jump))
  else
  begin
    fail_count++;
    $error("pc_is_jump has more than one bit set");
  end

  // the taken slot must be one that is fetched
  jump_in_valid: assert property (@(posedge clk) disable iff (reset)
    (pred.pc_is_jump & ~pred.pc_valid) == 4'b0000)
  else
  begin
    fail_count++;
    $error("pc_is_jump marks a slot outside pc_valid");
  end

  quiet_in_reset: assert property (@(posedge clk) reset |-> !bpu_flush)
  else
  begin
    fail_count++;
    $error("bpu_flush raised during reset");
  end

endmodule

bind bpu_top bpu_checker checker_i (
  .clk       (clk),
  .reset     (reset),
  .pred      (pred),
  .bpu_flush (bpu_flush)
);

// File: dv/bpu_tb.sv
// inputs change 1 ns after the rising edge; outputs checked against a cycle model at the falling edge
`timescale 1ns/1ps

module bpu_tb
  import bpu_pkg::*;
();

  localparam int reset_cycles    = 16;
  localparam int cold_lookups    = 32;
  localparam int directed_cycles = 24;
  localparam int mix_cycles      = 2000;
  localparam int run_cycles      = reset_cycles + cold_lookups + directed_cycles + ras_depth
                                   + mix_cycles;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic        fetch_stall;
  bpu_update_t upd;
  fetch_pred_t pred;
  logic        bpu_flush;
  logic [31:0] bpu_jump_pc;

  // reference state
  logic                   m_valid [btb_entries];
  logic [1:0]             m_ctr   [btb_entries];
  logic [1:0]             m_type  [btb_entries];
  logic [btb_tag_w-1:0]   m_tag   [btb_entries];
  logic [29:0]            m_tgt   [btb_entries];
  logic [29:0]            m_stack [ras_depth];
  logic [ras_ptr_w-1:0]   m_sp;
  logic [29:0]            m_q     [queue_depth];
  logic                   m_qv    [queue_depth];
  logic [queue_ptr_w-1:0] m_qh;
  logic [queue_ptr_w-1:0] m_qt;
  logic                   m_en;     // strobes live one edge after reset drops

  bpu_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .fetch_stall (fetch_stall),
    .upd         (upd),
    .pred        (pred),
    .bpu_flush   (bpu_flush),
    .bpu_jump_pc (bpu_jump_pc)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [btb_tag_w-1:0] tag_of(input logic [31:0] a);
    return a[17:8] ^ a[27:18];
  endfunction

  function automatic fetch_pred_t predict_ref(input logic [31:0] a);
    fetch_pred_t          p;
    int                   hit;
    logic [btb_idx_w-1:0] idx;
    logic [ras_ptr_w-1:0] top;
    p   = '0;
    hit = -1;
    for (int k = 0; k < 4; k++)
    begin
      idx = {a[7:4], 2'(k)};
      p.pc_valid[k] = (k >= a[3:2]);
      if (hit < 0 && p.pc_valid[k] && m_valid[idx] && m_tag[idx] == tag_of(a)
          && m_ctr[idx] >= 2'd2)
        hit = k;
    end
    if (hit < 0)
    begin
      p.next_pc = {a[31:4] + 28'd1, 4'b0000};
    end
    else
    begin
      idx = {a[7:4], 2'(hit)};
      top = m_sp - 1'b1;
      p.next_pc = (m_type[idx] == jt_return) ? {m_stack[top], 2'b00} : {m_tgt[idx], 2'b00};
      p.pc_is_jump[hit] = 1'b1;
      for (int k = hit + 1; k < 4; k++)
        p.pc_valid[k] = 1'b0; // fetch stops at the taken slot
    end
    return p;
  endfunction

  function automatic logic flush_ref(input bpu_update_t u);
    logic [btb_idx_w-1:0] idx;
    idx = u.pc[7:2];
    return u.may_jump && !u.in_excp && !u.is_ertn && u.need_jump && !u.pre_fail
           && m_valid[idx] && m_qv[m_qh] && (u.right_target[31:2] != m_q[m_qh]);
  endfunction

  task automatic advance_model();
    fetch_pred_t          p;
    logic                 fl;
    logic                 mean;
    logic                 hitv;
    logic                 match;
    logic [btb_idx_w-1:0] idx;
    if (reset)
    begin
      for (int i = 0; i < btb_entries; i++)
        m_valid[i] = 1'b0;
      for (int i = 0; i < queue_depth; i++)
        m_qv[i] = 1'b0;
      m_sp = '0;
      m_qh = '0;
      m_qt = '0;
      m_en = 1'b0;
    end
    else
    begin
      p     = predict_ref(pc);
      fl    = flush_ref(upd);
      mean  = upd.may_jump && !upd.in_excp && !upd.is_ertn;
      idx   = upd.pc[7:2];
      hitv  = m_valid[idx];
      match = hitv && (m_tag[idx] == tag_of(upd.pc));
      if (m_en)
      begin
        if (fl || upd.flush)
        begin
          for (int i = 0; i < queue_depth; i++)
            m_qv[i] = 1'b0;
          m_qh = '0;
          m_qt = '0;
        end
        else
        begin
          if (mean && upd.need_jump && !upd.pre_fail && hitv && m_qv[m_qh])
          begin
            m_qv[m_qh] = 1'b0; // head resolved with the right target
            m_qh       = m_qh + 1'b1;
          end
          if (p.pc_is_jump != 4'b0000 && !fetch_stall)
          begin
            m_q[m_qt]  = p.next_pc[31:2];
            m_qv[m_qt] = 1'b1;
            m_qt       = m_qt + 1'b1;
          end
        end
        if (mean && upd.need_jump && upd.jump_type == jt_call)
        begin
          m_stack[m_sp] = upd.pc[31:2] + 30'd1;
          m_sp          = m_sp + 1'b1;
        end
        else if (mean && upd.need_jump && upd.jump_type == jt_return && !fl)
          m_sp = m_sp - 1'b1;
      end
      if (mean && upd.need_jump)
      begin
        if (!match)
        begin
          m_valid[idx] = 1'b1;
          m_ctr[idx]   = 2'd2;
        end
        else if (m_ctr[idx] != 2'd3)
          m_ctr[idx] = m_ctr[idx] + 2'd1;
        m_type[idx] = upd.jump_type;
        m_tag[idx]  = tag_of(upd.pc);
        m_tgt[idx]  = upd.right_target[31:2];
      end
      else if (mean && match && m_ctr[idx] != 2'd0)
        m_ctr[idx] = m_ctr[idx] - 2'd1;
      m_en = 1'b1;
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(negedge clk)
  begin : compare
    fetch_pred_t exp;
    if (!reset)
    begin
      exp = predict_ref(pc);
      check_val("pred.next_pc", pred.next_pc, exp.next_pc);
      check_val("pred.pc_valid", pred.pc_valid, exp.pc_valid);
      check_val("pred.pc_is_jump", pred.pc_is_jump, exp.pc_is_jump);
      check_val("bpu_flush", bpu_flush, flush_ref(upd));
      check_val("bpu_jump_pc", bpu_jump_pc, upd.right_target);
    end
    advance_model();
  end

  // stop at the first assertion failure of the bound checker
  always @(dut_i.checker_i.fail_count)
  begin
    if (dut_i.checker_i.fail_count != 0)
    begin
      $display("Simulation failed");
      $fatal(1, "checker assertion failed");
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_lookup(input logic [31:0] a, input logic stall);
    pc          = a;
    fetch_stall = stall;
    upd         = '0;
  endtask

  task automatic drive_update(input logic [31:0] a, input logic taken, input logic [1:0] jt,
                              input logic [31:0] tgt);
    fetch_stall      = 1'b1;
    upd              = '0;
    upd.pc           = a;
    upd.may_jump     = 1'b1;
    upd.need_jump    = taken;
    upd.jump_type    = jt;
    upd.right_target = tgt;
  endtask

  task automatic expect_pred(input logic [31:0] next_pc, input logic [3:0] valid,
                             input logic [3:0] jump);
    #2;
    check_val("pred.next_pc", pred.next_pc, next_pc);
    check_val("pred.pc_valid", pred.pc_valid, valid);
    check_val("pred.pc_is_jump", pred.pc_is_jump, jump);
    next_cycle();
  endtask

  task automatic run_random_mix();
    logic [31:0] region;
    for (int i = 0; i < ras_depth; i++)
    begin
      drive_update(32'h0007_0100 + 32'(i) * 4, 1'b1, jt_call, 32'h0000_5000); // fill the stack
      next_cycle();
    end
    for (int i = 0; i < mix_cycles; i++)
    begin
      region           = ($urandom % 2) ? 32'h0005_2000 : 32'h0001_2000;
      pc               = region | ($urandom & 32'h0000_00fc);
      fetch_stall      = ($urandom % 4) == 0;
      upd              = '0;
      upd.flush        = ($urandom % 16) == 0;
      upd.in_excp      = ($urandom % 16) == 0;
      upd.is_ertn      = ($urandom % 16) == 0;
      upd.may_jump     = ($urandom % 4) != 0;
      upd.need_jump    = 1'($urandom % 2);
      upd.pre_fail     = ($urandom % 8) == 0;
      region           = ($urandom % 2) ? 32'h0005_2000 : 32'h0001_2000;
      upd.pc           = region | ($urandom & 32'h0000_00fc);
      upd.right_target = 32'h0000_4000 | (($urandom % 4) << 4);
      upd.jump_type    = 2'($urandom % 3);
      next_cycle();
    end
  endtask

  initial
  begin : stimulus
    logic [31:0] a;
    reset       = 1'b1;
    pc          = '0;
    fetch_stall = 1'b1;
    upd         = '0;
    void'($urandom(32'hc6f74ab5));
    @(posedge clk);
    #1;
    drive_update(32'h0001_2344, 1'b1, jt_call, 32'h0000_8000); // bus stays busy through reset
    repeat (reset_cycles - 1) @(posedge clk);
    #1;
    reset = 1'b0;

    // cold buffer predicts the next sequential group
    repeat (cold_lookups)
    begin
      a = $urandom;
      drive_lookup(a, 1'($urandom % 2));
      expect_pred({a[31:4] + 28'd1, 4'b0000}, 4'b1111 << a[3:2], 4'b0000);
    end

    // earliest live slot wins between two branches of one group
    drive_update(32'h0001_2344, 1'b1, jt_branch, 32'h0000_8000);
    next_cycle();
    drive_update(32'h0001_234c, 1'b1, jt_branch, 32'h0000_9000);
    next_cycle();
    drive_lookup(32'h0001_2340, 1'b1);
    expect_pred(32'h0000_8000, 4'b0011, 4'b0010);
    drive_lookup(32'h0001_2348, 1'b1);
    expect_pred(32'h0000_9000, 4'b1100, 4'b1000);

    // slot 3 takes over once the slot 1 counter drains to 0
    repeat (3)
    begin
      drive_update(32'h0001_2344, 1'b0, jt_branch, 32'h0000_8000);
      next_cycle();
    end
    drive_lookup(32'h0001_2340, 1'b1);
    expect_pred(32'h0000_9000, 4'b1111, 4'b1000);
    repeat (2)
    begin
      drive_update(32'h0001_2344, 1'b1, jt_branch, 32'h0000_8000);
      next_cycle();
    end
    drive_lookup(32'h0001_2340, 1'b1);
    expect_pred(32'h0000_8000, 4'b0011, 4'b0010);

    // return entry picks up the address after the call
    drive_update(32'h0004_0020, 1'b1, jt_return, 32'h0000_7000);
    next_cycle();
    drive_update(32'h0002_0010, 1'b1, jt_call, 32'h0003_0000);
    next_cycle();
    drive_lookup(32'h0004_0020, 1'b1);
    expect_pred(32'h0002_0014, 4'b0001, 4'b0001);

    // wrong target flushes while the right target only pops
    fetch_stall = 1'b1;
    upd         = '0;
    upd.flush   = 1'b1;
    next_cycle();
    drive_lookup(32'h0001_2340, 1'b0);
    next_cycle();
    drive_update(32'h0001_2344, 1'b1, jt_branch, 32'h0000_8800);
    #2;
    check_val("bpu_flush", bpu_flush, 32'd1);
    check_val("bpu_jump_pc", bpu_jump_pc, 32'h0000_8800);
    next_cycle();
    drive_lookup(32'h0001_2340, 1'b0);
    next_cycle();
    drive_update(32'h0001_2344, 1'b1, jt_branch, 32'h0000_8800);
    #2;
    check_val("bpu_flush", bpu_flush, 32'd0);
    next_cycle();

    run_random_mix();
    drive_lookup(32'h0000_0000, 1'b1);
    next_cycle();

    $display("Simulation completed successfully");
    $finish;
  end

  initial
  begin : watchdog
    #(run_cycles * 8 + 400);
    $display("watchdog expired before the tests finished, the run hung");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

// File: verilog.f
logic/bpu_pkg.sv
logic/bpu_ctrl.sv
logic/btb_pht.sv
logic/ras.sv
logic/target_queue.sv
logic/bpu_top.sv
dv/bpu_checker.sv
dv/bpu_tb.sv
